// ==== rtl/station_proto_pkg.sv ====
// command protocol definitions for the token station
// byte type, verb codes, response codes and sequencer states

package station_proto_pkg;

	typedef logic [7:0] byte_t;

	// verbs accepted in the first command byte
	typedef enum logic [7:0] {
		v_reset = 8'd0,
		v_ping  = 8'd2,
		v_go    = 8'd6
	} verb_t;

	typedef enum logic [7:0] {
		r_init  = 8'd1,
		r_error = 8'd2,
		r_done  = 8'd3,
		r_ack   = 8'd4,
		r_pong  = 8'd5
	} resp_t;

	typedef enum logic [3:0] {
		st_init, st_verb, st_red, st_blue, st_green, st_decode,
		st_echo, st_start, st_wait_done,
		st_send, st_busy_rise, st_busy_fall // shared transmit path
	} seq_state_t;

endpackage

// ==== rtl/servo_pkg.sv ====
// servo and dispenser types
// token count, pulse width and pwm frame counter

package servo_pkg;

	// tokens per dispenser, low nibble of a command argument
	typedef logic [3:0] token_count_t;

	typedef logic [15:0] servo_pos_t; // pulse width in clocks

	// position inside one pwm frame
	typedef logic [15:0] pwm_count_t;

endpackage

// ==== rtl/dispense_if.sv ====
// handshake between command sequencer and dispenser bank
// start pulse with three token counts, sticky done back

interface dispense_if;

	logic start; // one cycle, counts valid with it
	servo_pkg::token_count_t red_count;
	servo_pkg::token_count_t blue_count;
	servo_pkg::token_count_t green_count;
	logic done; // held until next start

	modport seq (
		output start, red_count, blue_count, green_count,
		input  done
	);

	modport bank (
		input  start, red_count, blue_count, green_count,
		output done
	);

endinterface

// ==== rtl/uart_tx.sv ====
// 8-N-1 serial transmitter
// start bit, eight data bits lsb first, stop bit
// busy from the cycle after tx_start until the stop bit ends

module uart_tx #(
	parameter int clks_per_bit = 434
) (
	input  logic                     clk50m,
	input  logic                     reset,
	input  logic                     tx_start,
	input  station_proto_pkg::byte_t tx_data,
	output logic                     tx_line,
	output logic                     tx_busy
);

	localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

	logic [cnt_w-1:0] baud_cnt;
	logic [3:0] bit_idx; // 0 start, 1..8 data, 9 stop
	logic [8:0] shift_q;
	logic bit_end;

	assign bit_end = (baud_cnt == cnt_w'(clks_per_bit - 1));

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			tx_line  <= 1'b1;
			tx_busy  <= 1'b0;
			baud_cnt <= '0;
			bit_idx  <= '0;
			shift_q  <= '1;
		end else if (!tx_busy) begin
			tx_line <= 1'b1;
			if (tx_start) begin
				shift_q  <= {1'b1, tx_data}; // stop bit rides in behind the data
				tx_line  <= 1'b0;
				tx_busy  <= 1'b1;
				baud_cnt <= '0;
				bit_idx  <= '0;
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			if (bit_idx == 4'd9) begin
				tx_busy <= 1'b0;
				tx_line <= 1'b1;
			end else begin
				bit_idx <= bit_idx + 4'd1;
				tx_line <= shift_q[0];
				shift_q <= {1'b1, shift_q[8:1]};
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// line idles high between frames
	a_idle_high: assert property (
		@(posedge clk50m) disable iff (!reset) !tx_busy |-> tx_line
	);

endmodule

// ==== rtl/token_dispenser.sv ====
// one servo dispenser
// pwm frame generator plus a counted eject/retract stroke loop
// done pulses for one cycle after the last stroke

module token_dispenser #(
	parameter int                    pwm_period    = 50000,
	parameter servo_pkg::servo_pos_t pulse_in      = 16'd20000,
	parameter servo_pkg::servo_pos_t pulse_out     = 16'd45000,
	parameter int                    stroke_frames = 20
) (
	input  logic                    clk50m,
	input  logic                    reset,
	input  logic                    start,
	input  servo_pkg::token_count_t count,
	output logic                    pwm_out,
	output logic                    done
);

	localparam int tally_w = (stroke_frames > 1) ? $clog2(stroke_frames) : 1;

	typedef enum logic [1:0] {idle, eject, retract} disp_state_t;

	disp_state_t state;
	servo_pkg::pwm_count_t frame_cnt;
	logic [tally_w-1:0] tally; // frames spent at the current position
	servo_pkg::token_count_t remaining;
	logic frame_end;
	logic stroke_end;

	assign frame_end  = (frame_cnt == servo_pkg::pwm_count_t'(pwm_period - 1));
	assign stroke_end = frame_end && (tally == tally_w'(stroke_frames - 1));

	// pulse width follows the current position
	assign pwm_out = (frame_cnt < ((state == eject) ? pulse_out : pulse_in));

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset)
			frame_cnt <= '0;
		else if (start || frame_end)
			frame_cnt <= '0; // realign frames on start
		else
			frame_cnt <= frame_cnt + 1'b1;
	end

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			state     <= idle;
			tally     <= '0;
			remaining <= '0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				tally     <= '0;
				remaining <= count;
				if (count == '0) begin
					state <= idle;
					done  <= 1'b1; // nothing to push
				end else begin
					state <= eject;
				end
			end else begin
				case (state)
					eject: begin
						if (stroke_end) begin
							tally <= '0;
							state <= retract;
						end else if (frame_end) begin
							tally <= tally + 1'b1;
						end
					end
					retract: begin
						if (stroke_end) begin
							tally     <= '0;
							remaining <= remaining - 1'b1;
							if (remaining == servo_pkg::token_count_t'(1)) begin
								state <= idle;
								done  <= 1'b1;
							end else begin
								state <= eject;
							end
						end else if (frame_end) begin
							tally <= tally + 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== rtl/dispenser_bank.sv ====
// red, blue and green dispensers behind one start/done handshake
// counts latched on start, per channel finished flags

module dispenser_bank #(
	parameter int                    pwm_period    = 50000,
	parameter servo_pkg::servo_pos_t pulse_in      = 16'd20000,
	parameter servo_pkg::servo_pos_t pulse_out     = 16'd45000,
	parameter int                    stroke_frames = 20
) (
	input  logic       clk50m,
	input  logic       reset,
	dispense_if.bank   dsp,
	output logic [2:0] pwm // red, blue, green
);

	servo_pkg::token_count_t red_q;
	servo_pkg::token_count_t blue_q;
	servo_pkg::token_count_t green_q;
	logic go_q; // start delayed to line up with the latched counts
	logic [2:0] ch_done;
	logic [2:0] finished;

	always_ff @(posedge clk50m) begin
		if (dsp.start) begin
			red_q   <= dsp.red_count;
			blue_q  <= dsp.blue_count;
			green_q <= dsp.green_count;
		end
	end

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			go_q     <= 1'b0;
			finished <= '0;
		end else begin
			go_q <= dsp.start;
			if (dsp.start)
				finished <= '0;
			else
				finished <= finished | ch_done; // sticky until next start
		end
	end

	assign dsp.done = &finished;

	token_dispenser #(
		.pwm_period(pwm_period), .pulse_in(pulse_in),
		.pulse_out(pulse_out), .stroke_frames(stroke_frames)
	) u_red (
		.clk50m(clk50m), .reset(reset), .start(go_q), .count(red_q),
		.pwm_out(pwm[0]), .done(ch_done[0])
	);

	token_dispenser #(
		.pwm_period(pwm_period), .pulse_in(pulse_in),
		.pulse_out(pulse_out), .stroke_frames(stroke_frames)
	) u_blue (
		.clk50m(clk50m), .reset(reset), .start(go_q), .count(blue_q),
		.pwm_out(pwm[1]), .done(ch_done[1])
	);

	token_dispenser #(
		.pwm_period(pwm_period), .pulse_in(pulse_in),
		.pulse_out(pulse_out), .stroke_frames(stroke_frames)
	) u_green (
		.clk50m(clk50m), .reset(reset), .start(go_q), .count(green_q),
		.pwm_out(pwm[2]), .done(ch_done[2])
	);

endmodule

// ==== rtl/command_sequencer.sv ====
// command sequencer for the token station
// collects verb plus three argument bytes, decodes the verb
// and steps through the reply bytes over one shared send path
// starts the dispenser bank for a go command

module command_sequencer (
	input  logic                      clk50m,
	input  logic                      reset,
	input  station_proto_pkg::byte_t  data,
	input  logic                      data_trig,
	input  logic                      tx_busy,
	output logic                      tx_start,
	output station_proto_pkg::byte_t  tx_data,
	dispense_if.seq                   dsp
);

	station_proto_pkg::seq_state_t state;
	station_proto_pkg::seq_state_t ret_state; // where to go after a send
	station_proto_pkg::byte_t verb_q;
	servo_pkg::token_count_t red_q;
	servo_pkg::token_count_t blue_q;
	servo_pkg::token_count_t green_q;

	assign dsp.start       = (state == station_proto_pkg::st_start);
	assign dsp.red_count   = red_q;
	assign dsp.blue_count  = blue_q;
	assign dsp.green_count = green_q;

	// command bytes are only taken while waiting for them
	always_ff @(posedge clk50m) begin
		if (data_trig) begin
			case (state)
				station_proto_pkg::st_verb:  verb_q  <= data;
				station_proto_pkg::st_red:   red_q   <= data[3:0];
				station_proto_pkg::st_blue:  blue_q  <= data[3:0];
				station_proto_pkg::st_green: green_q <= data[3:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk50m or negedge reset) begin
		if (!reset) begin
			state     <= station_proto_pkg::st_init;
			ret_state <= station_proto_pkg::st_verb;
			tx_start  <= 1'b0;
			tx_data   <= '0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				station_proto_pkg::st_init: begin // startup announcement
					tx_data   <= station_proto_pkg::r_init;
					ret_state <= station_proto_pkg::st_verb;
					state     <= station_proto_pkg::st_send;
				end
				station_proto_pkg::st_verb: begin
					if (data_trig)
						state <= station_proto_pkg::st_red;
				end
				station_proto_pkg::st_red: begin
					if (data_trig)
						state <= station_proto_pkg::st_blue;
				end
				station_proto_pkg::st_blue: begin
					if (data_trig)
						state <= station_proto_pkg::st_green;
				end
				station_proto_pkg::st_green: begin
					if (data_trig)
						state <= station_proto_pkg::st_decode;
				end
				station_proto_pkg::st_decode: begin
					ret_state <= station_proto_pkg::st_verb;
					state     <= station_proto_pkg::st_send;
					case (verb_q)
						station_proto_pkg::v_reset: state <= station_proto_pkg::st_init;
						station_proto_pkg::v_ping: tx_data <= station_proto_pkg::r_pong;
						station_proto_pkg::v_go: begin
							tx_data   <= station_proto_pkg::r_ack;
							ret_state <= station_proto_pkg::st_echo;
						end
						default: tx_data <= station_proto_pkg::r_error; // unknown verb
					endcase
				end
				station_proto_pkg::st_echo: begin
					tx_data   <= verb_q;
					ret_state <= station_proto_pkg::st_start;
					state     <= station_proto_pkg::st_send;
				end
				station_proto_pkg::st_start: begin
					state <= station_proto_pkg::st_wait_done; // start pulse is this state
				end
				station_proto_pkg::st_wait_done: begin
					if (dsp.done) begin
						tx_data   <= station_proto_pkg::r_done;
						ret_state <= station_proto_pkg::st_verb;
						state     <= station_proto_pkg::st_send;
					end
				end
				station_proto_pkg::st_send: begin
					if (!tx_busy) begin
						tx_start <= 1'b1;
						state    <= station_proto_pkg::st_busy_rise;
					end
				end
				station_proto_pkg::st_busy_rise: begin
					if (tx_busy)
						state <= station_proto_pkg::st_busy_fall;
				end
				station_proto_pkg::st_busy_fall: begin
					if (!tx_busy)
						state <= ret_state; // byte is out
				end
				default: state <= station_proto_pkg::st_init;
			endcase
		end
	end

	// a byte is never handed over while the transmitter is still busy
	a_tx_start_idle: assert property (
		@(posedge clk50m) disable iff (!reset) tx_start |-> !tx_busy
	);

	// dispense start is a single cycle pulse and the bank drops done on it
	a_start_pulse: assert property (
		@(posedge clk50m) disable iff (!reset) dsp.start |=> !dsp.start && !dsp.done
	);

endmodule

// ==== rtl/token_station_top.sv ====
// token station top level
// command sequencer, serial transmitter and dispenser bank
// defaults are for 50 MHz and 115200 baud

module token_station_top #(
	parameter int                    clks_per_bit  = 434,
	parameter int                    pwm_period    = 50000, // 1 ms frame
	parameter servo_pkg::servo_pos_t pulse_in      = 16'd20000,
	parameter servo_pkg::servo_pos_t pulse_out     = 16'd45000,
	parameter int                    stroke_frames = 20
) (
	input  logic                     clk50m,
	input  logic                     reset,
	input  station_proto_pkg::byte_t data,
	input  logic                     data_trig,
	output logic                     serial_return,
	output logic                     txbusy,
	output logic [2:0]               pwm
);

	logic tx_start;
	station_proto_pkg::byte_t tx_data;

	dispense_if dsp_bus ();

	command_sequencer u_seq (
		.clk50m(clk50m), .reset(reset), .data(data), .data_trig(data_trig),
		.tx_busy(txbusy), .tx_start(tx_start), .tx_data(tx_data), .dsp(dsp_bus.seq)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
		.clk50m(clk50m), .reset(reset), .tx_start(tx_start), .tx_data(tx_data),
		.tx_line(serial_return), .tx_busy(txbusy)
	);

	dispenser_bank #(
		.pwm_period(pwm_period), .pulse_in(pulse_in),
		.pulse_out(pulse_out), .stroke_frames(stroke_frames)
	) u_bank (
		.clk50m(clk50m), .reset(reset), .dsp(dsp_bus.bank), .pwm(pwm)
	);

endmodule

// ==== testbench/uart_monitor.sv ====
// serial receiver model for the testbench
// samples 8-N-1 frames in the middle of each bit
// strobes rx_valid for one cycle per received byte

module uart_monitor #(
	parameter int clks_per_bit = 8
) (
	input  logic                     clk50m,
	input  logic                     line,
	output station_proto_pkg::byte_t rx_data,
	output logic                     rx_valid,
	output logic                     rx_stop
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		rx_data  = '0;
		rx_valid = 1'b0;
		rx_stop  = 1'b1;
		forever begin
			@(negedge clk50m);
			if (!line) begin
				repeat (clks_per_bit / 2) @(negedge clk50m); // middle of start bit
				for (int i = 0; i < 8; i++) begin
					repeat (clks_per_bit) @(negedge clk50m);
					rx_data[i] = line; // lsb first
				end
				repeat (clks_per_bit) @(negedge clk50m);
				rx_stop  = line;
				rx_valid = 1'b1;
				@(negedge clk50m);
				rx_valid = 1'b0;
			end
		end
	end

endmodule

// ==== testbench/tb_token_station.sv ====
// testbench for the token station
// command stimulus, reply reference model and compare process
// strokes counted on the pwm lines, replies taken from uart_monitor

module tb_token_station;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clks_per_bit = 8;
	localparam int pwm_period = 40;
	localparam servo_pkg::servo_pos_t pulse_in = 16'd4;
	localparam servo_pkg::servo_pos_t pulse_out = 16'd12;
	localparam int stroke_frames = 2;
	localparam int wait_limit = 20000; // cycles per wait loop

	logic clk50m;
	logic reset;
	station_proto_pkg::byte_t data;
	logic data_trig;
	logic serial_return;
	logic txbusy;
	logic [2:0] pwm;
	station_proto_pkg::byte_t rx_data;
	logic rx_valid;
	logic rx_stop;
	station_proto_pkg::byte_t exp_q[$]; // replies still owed
	int high_len[3];
	int eject_pulses[3];
	int done_pulses[3]; // taken when r_done arrives
	integer seed;

	token_station_top #(
		.clks_per_bit(clks_per_bit), .pwm_period(pwm_period), .pulse_in(pulse_in),
		.pulse_out(pulse_out), .stroke_frames(stroke_frames)
	) u_dut (
		.clk50m(clk50m), .reset(reset), .data(data), .data_trig(data_trig),
		.serial_return(serial_return), .txbusy(txbusy), .pwm(pwm)
	);

	uart_monitor #(.clks_per_bit(clks_per_bit)) u_mon (
		.clk50m(clk50m), .line(serial_return), .rx_data(rx_data),
		.rx_valid(rx_valid), .rx_stop(rx_stop)
	);

	always #10 clk50m = ~clk50m;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at %0t", $time);
	endtask

	// reply bytes owed for one command
	function automatic void expect_reply(input station_proto_pkg::byte_t verb);
		case (verb)
			station_proto_pkg::v_reset: exp_q.push_back(station_proto_pkg::r_init);
			station_proto_pkg::v_ping: exp_q.push_back(station_proto_pkg::r_pong);
			station_proto_pkg::v_go: begin
				exp_q.push_back(station_proto_pkg::r_ack);
				exp_q.push_back(verb); // echo
				exp_q.push_back(station_proto_pkg::r_done);
			end
			default: exp_q.push_back(station_proto_pkg::r_error);
		endcase
	endfunction

	function automatic station_proto_pkg::byte_t rand_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic check_reply(input station_proto_pkg::byte_t got,
		input station_proto_pkg::byte_t exp);
		if (got !== exp)
			report_failure($sformatf("** Error at %0t: reply byte %0d, expected %0d",
				$time, got, exp));
	endtask

	task automatic check_tokens(input int ch, input servo_pkg::token_count_t exp);
		servo_pkg::token_count_t got;
		got = servo_pkg::token_count_t'(done_pulses[ch] / stroke_frames);
		if (done_pulses[ch] % stroke_frames != 0 || got !== exp)
			report_failure($sformatf("** Error at %0t: channel %0d gave %0d eject frames, %0s %0d",
				$time, ch, done_pulses[ch], "expected tokens", exp));
	endtask

	// eject pulses per channel, a frame realigned by start may stretch one
	always @(negedge clk50m) begin
		for (int ch = 0; ch < 3; ch++) begin
			if (pwm[ch]) begin
				high_len[ch] = high_len[ch] + 1;
			end else begin
				if (high_len[ch] >= int'(pulse_out))
					eject_pulses[ch] = eject_pulses[ch] + 1;
				high_len[ch] = 0;
			end
		end
	end

	// compare received bytes with the owed replies in order
	always @(posedge clk50m) begin
		if (rx_valid) begin
			if (exp_q.size() == 0) begin
				report_failure($sformatf("reply byte %0d arrived when none was owed", rx_data));
			end else begin
				if (!rx_stop)
					report_failure("serial frame ended without a stop bit");
				check_reply(rx_data, exp_q.pop_front());
				if (rx_data == station_proto_pkg::r_done)
					done_pulses = eject_pulses;
			end
		end
	end

	task automatic strobe_byte(input station_proto_pkg::byte_t b);
		@(posedge clk50m);
		data      <= b;
		data_trig <= 1'b1;
		@(posedge clk50m);
		data_trig <= 1'b0; // idle cycle follows
	endtask

	task automatic wait_busy();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk50m);
			cycles++;
		end while (!txbusy && cycles < wait_limit);
		if (!txbusy)
			report_failure("transmitter never started a reply");
	endtask

	task automatic wait_replies();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk50m);
			cycles++;
		end while (exp_q.size() != 0 && cycles < wait_limit);
		if (exp_q.size() != 0)
			report_failure($sformatf("timed out with %0d reply bytes missing", exp_q.size()));
		cycles = 0;
		while (txbusy && cycles < wait_limit) begin
			@(negedge clk50m);
			cycles++;
		end
		if (txbusy)
			report_failure("transmitter stayed busy after the last reply");
	endtask

	task automatic run_command(input station_proto_pkg::byte_t verb,
		input station_proto_pkg::byte_t red, input station_proto_pkg::byte_t blue,
		input station_proto_pkg::byte_t green, input logic stray);
		@(posedge clk50m);
		for (int ch = 0; ch < 3; ch++) begin
			eject_pulses[ch] = 0;
			done_pulses[ch]  = 0;
		end
		expect_reply(verb);
		strobe_byte(verb);
		strobe_byte(red);
		strobe_byte(blue);
		strobe_byte(green);
		if (stray) begin
			wait_busy();
			strobe_byte(8'h09); // lands during the ack, must be dropped
		end
		wait_replies();
		if (verb == station_proto_pkg::v_go) begin
			check_tokens(0, red[3:0]);
			check_tokens(1, blue[3:0]);
			check_tokens(2, green[3:0]);
		end
	endtask

	initial begin
		clk50m    = 1'b0;
		reset     = 1'b0;
		data      = '0;
		data_trig = 1'b0;
		seed      = 73;
		for (int ch = 0; ch < 3; ch++) begin
			high_len[ch]     = 0;
			eject_pulses[ch] = 0;
			done_pulses[ch]  = 0;
		end
		exp_q.push_back(station_proto_pkg::r_init); // startup announcement
		repeat (5) @(posedge clk50m);
		reset <= 1'b1;
		@(negedge clk50m);
		if (txbusy !== 1'b0 || serial_return !== 1'b1)
			report_failure("transmitter was not idle right after reset");
		wait_replies();
		run_command(station_proto_pkg::v_ping, rand_byte(), rand_byte(), rand_byte(), 1'b0);
		run_command(station_proto_pkg::v_go, 8'd2, 8'd0, 8'd1, 1'b0);
		repeat (3)
			run_command(station_proto_pkg::v_go, rand_byte(), rand_byte(), rand_byte(), 1'b0);
		run_command(8'd9, rand_byte(), rand_byte(), rand_byte(), 1'b0);
		run_command(station_proto_pkg::v_reset, 8'd0, 8'd0, 8'd0, 1'b0);
		run_command(station_proto_pkg::v_ping, 8'd7, 8'd7, 8'd7, 1'b0);
		run_command(station_proto_pkg::v_go, 8'd1, 8'd3, 8'd0, 1'b1);
		run_command(station_proto_pkg::v_ping, rand_byte(), rand_byte(), rand_byte(), 1'b0);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== project.f ====
rtl/station_proto_pkg.sv
rtl/servo_pkg.sv
rtl/dispense_if.sv
rtl/uart_tx.sv
rtl/token_dispenser.sv
rtl/dispenser_bank.sv
rtl/command_sequencer.sv
rtl/token_station_top.sv
testbench/uart_monitor.sv
testbench/tb_token_station.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_token_station -f project.f
	@out=$$(./obj_dir/Vtb_token_station); echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
